// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv32i_decode
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := include/rv32i_macros.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx 'TEST PASS' $(LOG)

check: run

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/rv32i_macros.svh ====
`ifndef RV32I_MACROS_SVH
`define RV32I_MACROS_SVH

// Base opcodes
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_OP_IMM  7'b0010011
`define RV_OP_OP      7'b0110011
`define RV_OP_FENCE   7'b0001111
`define RV_OP_SYSTEM  7'b1110011

// ALU funct3 codes, shared by OP and OP_IMM
`define RV_F3_ADD     3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SR      3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

`define RV_F7_BASE    7'b0000000
`define RV_F7_ALT     7'b0100000

`define AXI_ADDR_W    4
`define REG_INSTR     4'h0
`define REG_CTRL      4'h4
`define REG_IMM       4'h8
`define REG_ADDRS     4'hC

`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

// ==== logic/decode_axi_slave.sv ====
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module decode_axi_slave (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    awvalid,
    input  logic [`AXI_ADDR_W-1:0]  awaddr,
    output logic                    awready,
    input  logic                    wvalid,
    input  rv32i_pkg::word_t        wdata,
    input  logic [3:0]              wstrb,   // Full word writes only
    output logic                    wready,
    output logic                    bvalid,
    output rv32i_pkg::axi_resp_t    bresp,
    input  logic                    bready,
    input  logic                    arvalid,
    input  logic [`AXI_ADDR_W-1:0]  araddr,
    output logic                    arready,
    output logic                    rvalid,
    output rv32i_pkg::word_t        rdata,
    output rv32i_pkg::axi_resp_t    rresp,
    input  logic                    rready,
    output rv32i_pkg::instr_t       instr,
    input  rv32i_pkg::decode_ctrl_t ctrl,
    input  rv32i_pkg::word_t        imm,
    input  rv32i_pkg::reg_addrs_t   addrs
);

    rv32i_pkg::axi_state_e state;
    rv32i_pkg::instr_t     instr_q;
    rv32i_pkg::word_t      rd_word;
    rv32i_pkg::word_t      rdata_q;
    rv32i_pkg::word_t      ctrl_word;
    rv32i_pkg::word_t      addrs_word;
    rv32i_pkg::axi_resp_t  rd_resp;
    rv32i_pkg::axi_resp_t  bresp_q;
    rv32i_pkg::axi_resp_t  rresp_q;
    logic                  wr_take;
    logic                  rd_take;

    // Write pair wins over a read in the same cycle
    assign wr_take = (state == rv32i_pkg::IDLE) && awvalid && wvalid;
    assign rd_take = (state == rv32i_pkg::IDLE) && arvalid && !(awvalid && wvalid);

    assign awready = wr_take;
    assign wready  = wr_take;
    assign arready = rd_take;
    assign bvalid  = (state == rv32i_pkg::WRITE_RESP);
    assign rvalid  = (state == rv32i_pkg::READ_RESP);
    assign bresp   = bresp_q;
    assign rdata   = rdata_q;
    assign rresp   = rresp_q;
    assign instr   = instr_q;

    assign ctrl_word  = {{($bits(rv32i_pkg::word_t) - $bits(ctrl)){1'b0}}, ctrl};
    assign addrs_word = {{($bits(rv32i_pkg::word_t) - $bits(addrs)){1'b0}}, addrs};

    always_comb begin
        rd_resp = `AXI_RESP_OKAY;
        case (araddr)
            `REG_INSTR: rd_word = instr_q;
            `REG_CTRL:  rd_word = ctrl_word;
            `REG_IMM:   rd_word = imm;
            `REG_ADDRS: rd_word = addrs_word;
            default: begin
                rd_word = '0;
                rd_resp = `AXI_RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= rv32i_pkg::IDLE;
            instr_q <= '0;   // Decodes as illegal
        end else begin
            case (state)
                rv32i_pkg::IDLE: begin
                    if (wr_take) begin
                        state <= rv32i_pkg::WRITE_RESP;
                        if (awaddr == `REG_INSTR) begin
                            instr_q <= wdata;
                        end
                    end else if (rd_take) begin
                        state <= rv32i_pkg::READ_RESP;
                    end
                end
                rv32i_pkg::WRITE_RESP: begin
                    if (bready) begin
                        state <= rv32i_pkg::IDLE;
                    end
                end
                rv32i_pkg::READ_RESP: begin
                    if (rready) begin
                        state <= rv32i_pkg::IDLE;
                    end
                end
                default: state <= rv32i_pkg::IDLE;
            endcase
        end
    end

    // Response payload, held until the handshake completes
    always_ff @(posedge clk) begin
        if (wr_take) begin
            bresp_q <= (awaddr == `REG_INSTR) ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
        end
        if (rd_take) begin
            rdata_q <= rd_word;
            rresp_q <= rd_resp;
        end
    end

endmodule

// ==== logic/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
    input  rv32i_pkg::instr_t   instr,
    input  rv32i_pkg::imm_fmt_e fmt,
    output rv32i_pkg::word_t    imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (fmt)
            rv32i_pkg::IMM_I: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            rv32i_pkg::IMM_S: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            rv32i_pkg::IMM_B: begin
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rv32i_pkg::IMM_U: begin
                imm = {instr[31:12], 12'b0};
            end
            rv32i_pkg::IMM_J: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: imm = '0;  // No immediate
        endcase
    end

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module instr_decoder (
    input  rv32i_pkg::instr_t       instr,
    output rv32i_pkg::decode_ctrl_t ctrl,
    output rv32i_pkg::reg_addrs_t   addrs,
    output rv32i_pkg::imm_fmt_e     fmt
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       bad;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign alt    = (funct7 == `RV_F7_ALT);

    // Fixed field positions, valid or not
    assign addrs = '{rd: instr[11:7], rs1: instr[19:15], rs2: instr[24:20]};

    // funct3 to ALU op, sub_sra picks SUB or SRA
    function automatic rv32i_pkg::alu_op_e alu_from_f3(input logic [2:0] f3,
                                                       input logic       sub_sra);
        rv32i_pkg::alu_op_e op;
        case (f3)
            `RV_F3_ADD:  op = sub_sra ? rv32i_pkg::ALU_SUB : rv32i_pkg::ALU_ADD;
            `RV_F3_SLL:  op = rv32i_pkg::ALU_SLL;
            `RV_F3_SLT:  op = rv32i_pkg::ALU_SLT;
            `RV_F3_SLTU: op = rv32i_pkg::ALU_SLTU;
            `RV_F3_XOR:  op = rv32i_pkg::ALU_XOR;
            `RV_F3_SR:   op = sub_sra ? rv32i_pkg::ALU_SRA : rv32i_pkg::ALU_SRL;
            `RV_F3_OR:   op = rv32i_pkg::ALU_OR;
            default:     op = rv32i_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl = '0;
        fmt  = rv32i_pkg::IMM_NONE;
        bad  = 1'b0;
        case (opcode)
            `RV_OP_LUI: begin
                ctrl.instr_class = rv32i_pkg::CLASS_LUI;
                ctrl.reg_write   = 1'b1;
                fmt              = rv32i_pkg::IMM_U;
            end
            `RV_OP_AUIPC: begin
                ctrl.instr_class = rv32i_pkg::CLASS_AUIPC;
                ctrl.reg_write   = 1'b1;
                fmt              = rv32i_pkg::IMM_U;
            end
            `RV_OP_JAL: begin
                ctrl.instr_class = rv32i_pkg::CLASS_JAL;
                ctrl.reg_write   = 1'b1;
                fmt              = rv32i_pkg::IMM_J;
            end
            `RV_OP_JALR: begin
                ctrl.instr_class = rv32i_pkg::CLASS_JALR;
                ctrl.reg_write   = 1'b1;
                fmt              = rv32i_pkg::IMM_I;
                bad              = (funct3 != 3'b000);
            end
            `RV_OP_BRANCH: begin
                ctrl.instr_class = rv32i_pkg::CLASS_BRANCH;
                ctrl.alu_op      = rv32i_pkg::ALU_SUB;  // Compare by subtract
                ctrl.branch_cond = funct3;
                fmt              = rv32i_pkg::IMM_B;
                bad              = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            `RV_OP_LOAD: begin
                ctrl.instr_class = rv32i_pkg::CLASS_LOAD;
                ctrl.mem_width   = funct3;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                fmt              = rv32i_pkg::IMM_I;
                bad              = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            `RV_OP_STORE: begin
                ctrl.instr_class = rv32i_pkg::CLASS_STORE;
                ctrl.mem_width   = funct3;
                ctrl.mem_write   = 1'b1;
                fmt              = rv32i_pkg::IMM_S;
                bad              = (funct3 > 3'b010);
            end
            `RV_OP_OP_IMM: begin
                ctrl.instr_class = rv32i_pkg::CLASS_OP_IMM;
                ctrl.alu_op      = alu_from_f3(funct3, (funct3 == `RV_F3_SR) && alt);
                ctrl.reg_write   = 1'b1;
                fmt              = rv32i_pkg::IMM_I;
                // Upper immediate bits only constrained for shifts
                bad = ((funct3 == `RV_F3_SLL) && (funct7 != `RV_F7_BASE)) ||
                      ((funct3 == `RV_F3_SR) && (funct7 != `RV_F7_BASE) && !alt);
            end
            `RV_OP_OP: begin
                ctrl.instr_class = rv32i_pkg::CLASS_OP;
                ctrl.alu_op      = alu_from_f3(funct3, alt);
                ctrl.reg_write   = 1'b1;
                bad = !((funct7 == `RV_F7_BASE) ||
                        (alt && ((funct3 == `RV_F3_ADD) || (funct3 == `RV_F3_SR))));
            end
            `RV_OP_FENCE: begin
                ctrl.instr_class = rv32i_pkg::CLASS_FENCE;  // No-op here
                bad              = (funct3 != 3'b000);
            end
            `RV_OP_SYSTEM: begin
                ctrl.instr_class  = rv32i_pkg::CLASS_SYSTEM;
                ctrl.system_break = instr[20];
                // Only ECALL and EBREAK, no CSR access
                bad = (instr[31:21] != '0) || (instr[19:7] != '0);
            end
            default: bad = 1'b1;
        endcase

        if (bad) begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
            fmt          = rv32i_pkg::IMM_NONE;
        end
    end

endmodule

// ==== logic/rv32i_decode_top.sv ====
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module rv32i_decode_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   awvalid,
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    output logic                   awready,
    input  logic                   wvalid,
    input  rv32i_pkg::word_t       wdata,
    input  logic [3:0]             wstrb,
    output logic                   wready,
    output logic                   bvalid,
    output rv32i_pkg::axi_resp_t   bresp,
    input  logic                   bready,
    input  logic                   arvalid,
    input  logic [`AXI_ADDR_W-1:0] araddr,
    output logic                   arready,
    output logic                   rvalid,
    output rv32i_pkg::word_t       rdata,
    output rv32i_pkg::axi_resp_t   rresp,
    input  logic                   rready
);

    rv32i_pkg::instr_t       instr;
    rv32i_pkg::decode_ctrl_t ctrl;
    rv32i_pkg::reg_addrs_t   addrs;
    rv32i_pkg::imm_fmt_e     fmt;
    rv32i_pkg::word_t        imm;

    decode_axi_slave i_decode_axi_slave (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awaddr  (awaddr),
        .awready (awready),
        .wvalid  (wvalid),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wready  (wready),
        .bvalid  (bvalid),
        .bresp   (bresp),
        .bready  (bready),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arready (arready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rready  (rready),
        .instr   (instr),
        .ctrl    (ctrl),
        .imm     (imm),
        .addrs   (addrs)
    );

    // Decode is combinational off the instruction register
    instr_decoder i_instr_decoder (
        .instr (instr),
        .ctrl  (ctrl),
        .addrs (addrs),
        .fmt   (fmt)
    );

    imm_gen i_imm_gen (
        .instr (instr),
        .fmt   (fmt),
        .imm   (imm)
    );

endmodule

// ==== logic/rv32i_pkg.sv ====
package rv32i_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [1:0]  axi_resp_t;

    typedef enum logic [3:0] {
        CLASS_LUI    = 4'd0,
        CLASS_AUIPC  = 4'd1,
        CLASS_JAL    = 4'd2,
        CLASS_JALR   = 4'd3,
        CLASS_BRANCH = 4'd4,
        CLASS_LOAD   = 4'd5,
        CLASS_STORE  = 4'd6,
        CLASS_OP_IMM = 4'd7,
        CLASS_OP     = 4'd8,
        CLASS_FENCE  = 4'd9,
        CLASS_SYSTEM = 4'd10
    } instr_class_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_e;

    // Read back zero-extended, MSB first
    typedef struct packed {
        instr_class_e instr_class;
        alu_op_e      alu_op;
        logic [2:0]   mem_width;    // funct3 of loads and stores
        logic [2:0]   branch_cond;  // funct3 of branches
        logic         reg_write;
        logic         mem_read;
        logic         mem_write;
        logic         system_break; // EBREAK
        logic         illegal;
    } decode_ctrl_t;

    typedef struct packed {
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } reg_addrs_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        READ_RESP
    } axi_state_e;

endpackage

// ==== sim.f ====
+incdir+include
logic/rv32i_pkg.sv
logic/decode_axi_slave.sv
logic/instr_decoder.sv
logic/imm_gen.sv
logic/rv32i_decode_top.sv
tb/rv32i_decode_properties.sv
tb/tb_rv32i_decode.sv

// ==== tb/decode_golden.mem ====
// Columns: instruction, control word, immediate, register addresses (all hex)
// Control and addresses are the zero-extended read-back values
800002B7 00000010 80000000 00001400
12345097 00008010 12345000 00000503
FFDFF0EF 00010010 FFFFFFFC 000007FD
FF8100E7 00018010 FFFFFFF8 00000458
00310463 00020800 00000008 00002043
FE3118E3 00020820 FFFFFFF0 00004443
00314463 00020880 00000008 00002043
00315463 000208A0 00000008 00002043
00316463 000208C0 00000008 00002043
00317463 000208E0 00000008 00002043
00410083 00028018 00000004 00000444
00411083 00028118 00000004 00000444
FFC12083 00028218 FFFFFFFC 0000045C
00414083 00028418 00000004 00000444
00415083 00028518 00000004 00000444
00310423 00030004 00000008 00002043
00311423 00030104 00000008 00002043
FE312C23 00030204 FFFFFFF8 00006043
003100B3 00040010 00000000 00000443
403100B3 00040810 00000000 00000443
003110B3 00041010 00000000 00000443
003120B3 00041810 00000000 00000443
003130B3 00042010 00000000 00000443
003140B3 00042810 00000000 00000443
003150B3 00043010 00000000 00000443
403150B3 00043810 00000000 00000443
003160B3 00044010 00000000 00000443
003170B3 00044810 00000000 00000443
FFF10093 00038010 FFFFFFFF 0000045F
40315093 0003B810 00000403 00000443
0FF0000F 00048000 00000000 0000001F
00000073 00050000 00000000 00000000
00100073 00050002 00000000 00000001
FFFFFFFF 00000001 00000000 00007FFF
023100B3 00000001 00000000 00000443
403140B3 00000001 00000000 00000443

// ==== tb/rv32i_decode_properties.sv ====
`timescale 1ns/1ps

module rv32i_decode_properties (
    input logic             clk,
    input logic             rst,
    input logic             awvalid,
    input logic             awready,
    input logic             wvalid,
    input logic             wready,
    input logic             bvalid,
    input logic             bready,
    input logic             arvalid,
    input logic             arready,
    input logic             rvalid,
    input logic             rready,
    input rv32i_pkg::word_t rdata
);

    int fail_count = 0;

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid)
    else begin
        $error("awvalid dropped before awready");
        fail_count++;
    end
    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid)
    else begin
        $error("wvalid dropped before wready");
        fail_count++;
    end
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid)
    else begin
        $error("arvalid dropped before arready");
        fail_count++;
    end
    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
    else begin
        $error("bvalid dropped before bready");
        fail_count++;
    end
    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
        $error("rdata changed before rready");
        fail_count++;
    end
    a_one_resp: assert property (@(posedge clk) disable iff (rst)
        !(bvalid && rvalid))
    else begin
        $error("bvalid and rvalid high together");
        fail_count++;
    end
    a_no_accept: assert property (@(posedge clk) disable iff (rst)
        (bvalid || rvalid) |-> !awready && !arready)
    else begin
        $error("address taken during response");
        fail_count++;
    end
    a_reset: assert property (@(posedge clk)
        rst |=> !bvalid && !rvalid)
    else begin
        $error("response valid right after reset");
        fail_count++;
    end

endmodule

bind decode_axi_slave rv32i_decode_properties i_rv32i_decode_properties (
    .clk(clk), .rst(rst), .awvalid(awvalid), .awready(awready), .wvalid(wvalid),
    .wready(wready), .bvalid(bvalid), .bready(bready), .arvalid(arvalid),
    .arready(arready), .rvalid(rvalid), .rready(rready), .rdata(rdata)
);

// ==== tb/tb_rv32i_decode.sv ====
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module tb_rv32i_decode;

    localparam int MAX_TESTS = 64;
    localparam int TIMEOUT_CYCLES = 20;

    logic                   clk;
    logic                   rst;
    logic                   awvalid;
    logic [`AXI_ADDR_W-1:0] awaddr;
    logic                   awready;
    logic                   wvalid;
    rv32i_pkg::word_t       wdata;
    logic [3:0]             wstrb;
    logic                   wready;
    logic                   bvalid;
    rv32i_pkg::axi_resp_t   bresp;
    logic                   bready;
    logic                   arvalid;
    logic [`AXI_ADDR_W-1:0] araddr;
    logic                   arready;
    logic                   rvalid;
    rv32i_pkg::word_t       rdata;
    rv32i_pkg::axi_resp_t   rresp;
    logic                   rready;

    rv32i_pkg::word_t gold [0:4*MAX_TESTS-1];
    int data_errs;
    int resp_errs;
    int timeout_errs;
    int n_tests;

    rv32i_decode_top i_rv32i_decode_top (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
        .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic finish_run();
        int prop_errs;
        prop_errs = i_rv32i_decode_top.i_decode_axi_slave.i_rv32i_decode_properties.fail_count;
        $display("Errors: data %0d, response %0d, timeout %0d, protocol %0d", data_errs,
                 resp_errs, timeout_errs, prop_errs);
        if (data_errs == 0 && resp_errs == 0 && timeout_errs == 0 && prop_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    function automatic logic sig_high(input int sel);
        case (sel)
            0: return awready && wready;
            1: return arready;
            2: return bvalid;
            default: return rvalid;
        endcase
    endfunction

    // Samples 1 ns after the falling edge, returns there
    task automatic wait_high(input int sel, input string what);
        int cycles;
        cycles = 0;
        #1;
        while (!sig_high(sel) && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (!sig_high(sel)) begin
            $display("Timeout while waiting for %s to go high", what);
            timeout_errs++;
            finish_run();
        end
    endtask

    task automatic check_word(input string name, input rv32i_pkg::word_t got,
                              input rv32i_pkg::word_t exp);
        assert (got === exp) else begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_resp(input string name, input rv32i_pkg::axi_resp_t got,
                              input rv32i_pkg::axi_resp_t exp);
        assert (got === exp) else begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            resp_errs++;
        end
    endtask

    // Read address already on the bus, finishes the transfer
    task automatic complete_read(input rv32i_pkg::word_t exp_data,
                                 input rv32i_pkg::axi_resp_t exp_resp, input string name);
        rv32i_pkg::word_t held;
        int delay;
        wait_high(1, "arready");
        @(negedge clk);
        arvalid = 1'b0;
        wait_high(3, "rvalid");
        held  = rdata;
        delay = $urandom % 4;
        repeat (delay + 1) @(negedge clk);
        rready = 1'b1;
        #1;
        assert (rvalid) else begin
            $display("rvalid dropped before rready was raised");
            resp_errs++;
        end
        check_word(name, rdata, exp_data);
        check_word("rdata held", rdata, held);
        check_resp("rresp", rresp, exp_resp);
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic axi_write(input logic [3:0] addr, input rv32i_pkg::word_t data,
                             input rv32i_pkg::axi_resp_t exp_resp,
                             input rv32i_pkg::word_t exp_instr);
        rv32i_pkg::axi_resp_t first;
        int delay;
        @(negedge clk);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = 4'hF;
        wait_high(0, "awready and wready");
        @(negedge clk);  // Pair taken at the edge just passed
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b1;  // Read-back queued behind the write response
        araddr  = `REG_INSTR;
        wait_high(2, "bvalid");
        first = bresp;
        delay = $urandom % 4;
        repeat (delay + 1) begin
            @(negedge clk);
            #1;
            assert (!arready) else begin
                $display("Read accepted while the write response was pending");
                resp_errs++;
            end
        end
        bready = 1'b1;
        #1;
        assert (bvalid) else begin
            $display("bvalid dropped before bready was raised");
            resp_errs++;
        end
        check_resp("bresp", bresp, exp_resp);
        check_resp("bresp held", bresp, first);
        @(negedge clk);
        bready = 1'b0;
        complete_read(exp_instr, `AXI_RESP_OKAY, "instr");
    endtask

    task automatic axi_read(input logic [3:0] addr, input rv32i_pkg::word_t exp_data,
                            input rv32i_pkg::axi_resp_t exp_resp, input string name);
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        complete_read(exp_data, exp_resp, name);
    endtask

    initial begin
        void'($urandom(32'h20b2));
        data_errs    = 0;
        resp_errs    = 0;
        timeout_errs = 0;
        rst     = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = 4'h0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;

        for (int i = 0; i < 4 * MAX_TESTS; i++) begin
            gold[i] = 32'hDEAD0000 | i;  // Marks lines the file did not fill
        end
        $readmemh("tb/decode_golden.mem", gold);
        n_tests = 0;
        while (n_tests < MAX_TESTS && gold[4*n_tests] !== (32'hDEAD0000 | (4 * n_tests))) begin
            n_tests++;
        end
        assert (n_tests > 0) else begin
            $display("Golden file holds no test lines");
            data_errs++;
        end

        repeat (8) @(negedge clk);
        rst = 1'b0;

        // Zero instruction decodes as illegal
        axi_read(`REG_CTRL, 32'h0000_0001, `AXI_RESP_OKAY, "ctrl after reset");

        for (int t = 0; t < n_tests; t++) begin
            axi_write(`REG_INSTR, gold[4*t], `AXI_RESP_OKAY, gold[4*t]);
            axi_read(`REG_CTRL, gold[4*t+1], `AXI_RESP_OKAY, "ctrl");
            axi_read(`REG_IMM, gold[4*t+2], `AXI_RESP_OKAY, "imm");
            axi_read(`REG_ADDRS, gold[4*t+3], `AXI_RESP_OKAY, "addrs");
        end

        if (n_tests > 0) begin
            axi_write(`REG_CTRL, 32'hDEADBEEF, `AXI_RESP_SLVERR, gold[4*(n_tests-1)]);
        end
        axi_read(4'h6, 32'h0, `AXI_RESP_SLVERR, "unmapped rdata");
        axi_read(4'h3, 32'h0, `AXI_RESP_SLVERR, "unmapped rdata");

        finish_run();
    end

endmodule
